// File: include/exu_config.svh
// execute slice widths
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// integer data path
`define EXU_XLEN 32

// architectural register index, x0..x31
`define EXU_REG_ADDR_W 5

// commit tag carried alongside each instruction
// wide enough for the in-flight window of the core
`define EXU_COMMIT_ID_W 4

`endif

// File: rtl/exu_types_pkg.sv
// execute slice scalar types
`include "exu_config.svh"

package exu_types_pkg;

    // data word, register index, instruction tag
    typedef logic [`EXU_XLEN-1:0]        xlen_t;
    typedef logic [`EXU_REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [`EXU_COMMIT_ID_W-1:0] commit_id_t;

    //////////////////////////////////////////////////////////////////////
    // one-hot alu operation
    //////////////////////////////////////////////////////////////////////
    localparam int ALU_OP_W = 13;

    typedef logic [ALU_OP_W-1:0] alu_op_t;

    // bit positions inside alu_op_t
    localparam int ALU_ADD   = 0;
    localparam int ALU_SUB   = 1;
    localparam int ALU_SLL   = 2;
    localparam int ALU_SLT   = 3;
    localparam int ALU_SLTU  = 4;
    localparam int ALU_XOR   = 5;
    localparam int ALU_SRL   = 6;
    localparam int ALU_SRA   = 7;
    localparam int ALU_OR    = 8;
    localparam int ALU_AND   = 9;
    // op2 carries the upper immediate
    localparam int ALU_LUI   = 10;
    // op1 = pc, op2 = upper immediate
    localparam int ALU_AUIPC = 11;
    // link address, op1 = pc, op2 = 4
    localparam int ALU_JUMP  = 12;

endpackage

// File: rtl/exu_if_pkg.sv
// execute slice stage payloads

package exu_if_pkg;

    import exu_types_pkg::*;

    // one issued instruction, operands already read from the register file
    typedef struct packed {
        alu_op_t    op;
        xlen_t      op1;
        xlen_t      op2;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        // operand came from a register read, so it may be forwarded
        logic       op1_is_reg;
        logic       op2_is_reg;
        reg_addr_t  rd;
        logic       reg_we;
        commit_id_t commit_id;
    } exu_issue_t;

    // one result on its way to writeback
    typedef struct packed {
        xlen_t      data;
        reg_addr_t  rd;
        logic       reg_we;
        commit_id_t commit_id;
    } exu_wb_t;

endpackage

// File: rtl/exu_fwd_ctrl.sv
// operand forwarding from the last result
`timescale 1ns/1ns

module exu_fwd_ctrl
    import exu_types_pkg::*;
    import exu_if_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  exu_issue_t issue_i,
    input  logic       flush_i,
    input  logic       accept_i,
    input  xlen_t      alu_result_i,
    output xlen_t      op1_o,
    output xlen_t      op2_o
);

    // record of the last register-writing instruction
    logic      last_valid_q;
    reg_addr_t last_rd_q;
    xlen_t     last_data_q;
    logic      record_we;
    logic      fwd_op1;
    logic      fwd_op2;

    // flushed instructions never enter the record
    assign record_we = accept_i && issue_i.reg_we && !flush_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_valid_q <= 1'b0;
            last_rd_q    <= '0;
        end else if (record_we) begin
            last_valid_q <= 1'b1;
            last_rd_q    <= issue_i.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (record_we) begin
            last_data_q <= alu_result_i;
        end
    end

    // x0 and immediates are never forwarded
    assign fwd_op1 = issue_i.op1_is_reg && last_valid_q
                     && (issue_i.rs1 != '0) && (issue_i.rs1 == last_rd_q);
    assign fwd_op2 = issue_i.op2_is_reg && last_valid_q
                     && (issue_i.rs2 != '0) && (issue_i.rs2 == last_rd_q);

    assign op1_o = fwd_op1 ? last_data_q : issue_i.op1;
    assign op2_o = fwd_op2 ? last_data_q : issue_i.op2;

endmodule

// File: rtl/exu_alu.sv
// rv32i integer alu
`timescale 1ns/1ns

module exu_alu
    import exu_types_pkg::*;
    import exu_if_pkg::*;
(
    input  exu_issue_t issue_i,
    input  logic       flush_i,
    input  xlen_t      op1_i,
    input  xlen_t      op2_i,
    output exu_wb_t    wb_o
);

    localparam int XLEN    = $bits(xlen_t);
    localparam int SHAMT_W = $clog2(XLEN);

    // mirror a word end to end
    function automatic xlen_t reverse_bits(input xlen_t v);
        xlen_t r;
        for (int i = 0; i < XLEN; i++) begin
            r[i] = v[XLEN-1-i];
        end
        return r;
    endfunction

    // operation decode
    logic op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl;
    logic op_sra, op_or, op_and, op_lui, op_auipc, op_jump;
    logic op_right;
    logic op_negate;

    assign op_add   = issue_i.op[ALU_ADD];
    assign op_sub   = issue_i.op[ALU_SUB];
    assign op_sll   = issue_i.op[ALU_SLL];
    assign op_slt   = issue_i.op[ALU_SLT];
    assign op_sltu  = issue_i.op[ALU_SLTU];
    assign op_xor   = issue_i.op[ALU_XOR];
    assign op_srl   = issue_i.op[ALU_SRL];
    assign op_sra   = issue_i.op[ALU_SRA];
    assign op_or    = issue_i.op[ALU_OR];
    assign op_and   = issue_i.op[ALU_AND];
    assign op_lui   = issue_i.op[ALU_LUI];
    assign op_auipc = issue_i.op[ALU_AUIPC];
    assign op_jump  = issue_i.op[ALU_JUMP];

    assign op_right  = op_srl | op_sra;
    // subtract and both compares go through op1 + ~op2 + 1
    assign op_negate = op_sub | op_slt | op_sltu;

    //////////////////////////////////////////////////////////////////////
    // shared adder
    //////////////////////////////////////////////////////////////////////
    xlen_t           adder_in2;
    logic [XLEN:0]   adder_res;
    logic            lt_signed;
    logic            lt_unsigned;

    assign adder_in2 = op_negate ? ~op2_i : op2_i;
    assign adder_res = {1'b0, op1_i} + {1'b0, adder_in2} + {{XLEN{1'b0}}, op_negate};

    // signs differ: the negative one is smaller
    // signs agree: no overflow, so the difference sign decides
    assign lt_signed = (op1_i[XLEN-1] != op2_i[XLEN-1]) ? op1_i[XLEN-1]
                                                         : adder_res[XLEN-1];
    // no carry out means a borrow, op1 < op2
    assign lt_unsigned = ~adder_res[XLEN];

    //////////////////////////////////////////////////////////////////////
    // shared left shifter, right shifts by reversal
    //////////////////////////////////////////////////////////////////////
    logic [SHAMT_W-1:0] shamt;
    xlen_t              shift_in;
    xlen_t              shift_res;
    xlen_t              srl_res;
    xlen_t              sra_mask;
    xlen_t              sra_res;

    assign shamt     = op2_i[SHAMT_W-1:0];
    assign shift_in  = op_right ? reverse_bits(op1_i) : op1_i;
    assign shift_res = shift_in << shamt;
    assign srl_res   = reverse_bits(shift_res);

    // ones where the logical shift left zeros behind
    assign sra_mask = ~({XLEN{1'b1}} >> shamt);
    assign sra_res  = (srl_res & ~sra_mask) | ({XLEN{op1_i[XLEN-1]}} & sra_mask);

    //////////////////////////////////////////////////////////////////////
    // result select, one-hot and-or
    //////////////////////////////////////////////////////////////////////
    xlen_t result;

    assign result = ({XLEN{op_add | op_sub | op_auipc | op_jump}} & adder_res[XLEN-1:0])
                  | ({XLEN{op_sll}}  & shift_res)
                  | ({XLEN{op_srl}}  & srl_res)
                  | ({XLEN{op_sra}}  & sra_res)
                  | ({XLEN{op_slt}}  & {{(XLEN-1){1'b0}}, lt_signed})
                  | ({XLEN{op_sltu}} & {{(XLEN-1){1'b0}}, lt_unsigned})
                  | ({XLEN{op_xor}}  & (op1_i ^ op2_i))
                  | ({XLEN{op_or}}   & (op1_i | op2_i))
                  | ({XLEN{op_and}}  & (op1_i & op2_i))
                  | ({XLEN{op_lui}}  & op2_i);

    // flushed slot keeps its tag but writes nothing
    assign wb_o.data      = result;
    assign wb_o.rd        = flush_i ? '0 : issue_i.rd;
    assign wb_o.reg_we    = issue_i.reg_we & ~flush_i;
    assign wb_o.commit_id = issue_i.commit_id;

endmodule

// File: rtl/exu_wb_buffer.sv
// one-entry writeback buffer
`timescale 1ns/1ns

module exu_wb_buffer
    import exu_if_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid_i,
    input  exu_wb_t in_i,
    output logic    in_ready_o,
    output logic    out_valid_o,
    output exu_wb_t out_o,
    input  logic    out_ready_i
);

    logic    valid_q;
    exu_wb_t data_q;
    logic    load;
    logic    drain;

    // free now, or emptied on this same edge
    assign in_ready_o = ~valid_q | out_ready_i;

    assign load  = in_valid_i & in_ready_o;
    assign drain = valid_q & out_ready_i;

    //////////////////////////////////////////////////////////////////////
    // occupancy
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (load) begin
            // refill wins over drain
            valid_q <= 1'b1;
        end else if (drain) begin
            valid_q <= 1'b0;
        end
    end

    // payload only moves on an input handshake
    // held stable while stalled downstream
    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= in_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_o       = data_q;

endmodule

// File: rtl/exu_top.sv
// integer execute slice
`timescale 1ns/1ns

module exu_top
    import exu_types_pkg::*;
    import exu_if_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // issue port
    input  logic       issue_valid_i,
    input  exu_issue_t issue_i,
    input  logic       flush_i,
    output logic       issue_ready_o,
    // writeback port
    output logic       wb_valid_o,
    output exu_wb_t    wb_o,
    input  logic       wb_ready_i
);

    xlen_t   op1;
    xlen_t   op2;
    exu_wb_t alu_wb;
    logic    accept;

    // issue handshake
    assign accept = issue_valid_i & issue_ready_o;

    exu_fwd_ctrl u_fwd (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_i      (issue_i),
        .flush_i      (flush_i),
        .accept_i     (accept),
        .alu_result_i (alu_wb.data),
        .op1_o        (op1),
        .op2_o        (op2)
    );

    exu_alu u_alu (
        .issue_i (issue_i),
        .flush_i (flush_i),
        .op1_i   (op1),
        .op2_i   (op2),
        .wb_o    (alu_wb)
    );

    exu_wb_buffer u_wb_buf (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (issue_valid_i),
        .in_i        (alu_wb),
        .in_ready_o  (issue_ready_o),
        .out_valid_o (wb_valid_o),
        .out_o       (wb_o),
        .out_ready_i (wb_ready_i)
    );

endmodule

// File: verif/exu_checker.sv
// writeback buffer assertions
`timescale 1ns/1ns

module exu_checker
    import exu_if_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    out_valid_o,
    input logic    out_ready_i,
    input exu_wb_t out_o
);

    // stalled result must hold still and stay valid
    assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_o)))
        else $error("writeback payload changed while stalled");

    // nothing offered while in reset
    assert property (@(posedge clk) !rst_n |-> !out_valid_o)
        else $error("writeback valid high during reset");

    // x0 is never a write target
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_o |-> !(out_o.reg_we && (out_o.rd == '0)))
        else $error("writeback enables a write to x0");

endmodule

bind exu_wb_buffer exu_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_o       (out_o)
);

// File: verif/exu_tb.sv
// execute slice testbench
`timescale 1ns/1ns

module exu_tb
    import exu_types_pkg::*;
    import exu_if_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_ROWS        = 26;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 20 + RESET_CYCLES;

    logic       clk;
    logic       rst_n;
    logic       issue_valid_i;
    exu_issue_t issue_i;
    logic       flush_i;
    logic       issue_ready_o;
    logic       wb_valid_o;
    exu_wb_t    wb_o;
    logic       wb_ready_i;

    integer     seed = 79;
    int         n_rows;
    int         n_got;

    // stimulus table
    string      row_name  [NUM_ROWS];
    exu_issue_t row_issue [NUM_ROWS];
    logic       row_flush [NUM_ROWS];
    exu_wb_t    row_exp   [NUM_ROWS];

    exu_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .flush_i       (flush_i),
        .issue_ready_o (issue_ready_o),
        .wb_valid_o    (wb_valid_o),
        .wb_o          (wb_o),
        .wb_ready_i    (wb_ready_i)
    );

    //////////////////////////////////////////////////////////////////////
    // reporting and compares
    //////////////////////////////////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input xlen_t exp, input xlen_t act);
        if (exp !== act)
            abort_run($sformatf("ERROR %s: data expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_rd(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (exp !== act)
            abort_run($sformatf("ERROR %s: rd expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_id(input string name, input commit_id_t exp, input commit_id_t act);
        if (exp !== act)
            abort_run($sformatf("ERROR %s: commit id expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_we(input string name, input logic exp, input logic act);
        if (exp !== act)
            abort_run($sformatf("ERROR %s: reg_we expected %b, actual %b", name, exp, act));
    endtask

    // flags = {op1_is_reg, op2_is_reg, reg_we, flush}
    task automatic add_row(input string name, input int op_bit, input xlen_t op1,
                           input xlen_t op2, input reg_addr_t rs1, input reg_addr_t rs2,
                           input reg_addr_t rd, input logic [3:0] flags,
                           input xlen_t exp_data);
        exu_issue_t iss;
        exu_wb_t    exp;
        iss            = '0;
        iss.op[op_bit] = 1'b1;
        iss.op1        = op1;
        iss.op2        = op2;
        iss.rs1        = rs1;
        iss.rs2        = rs2;
        iss.op1_is_reg = flags[3];
        iss.op2_is_reg = flags[2];
        iss.rd         = rd;
        iss.reg_we     = flags[1];
        iss.commit_id  = commit_id_t'(n_rows);
        // a flushed slot keeps its tag and data but writes nowhere
        exp.data       = exp_data;
        exp.rd         = flags[0] ? '0 : rd;
        exp.reg_we     = flags[1] & ~flags[0];
        exp.commit_id  = commit_id_t'(n_rows);
        row_name[n_rows]  = name;
        row_issue[n_rows] = iss;
        row_flush[n_rows] = flags[0];
        row_exp[n_rows]   = exp;
        n_rows++;
    endtask

    task automatic build_table();
        n_rows = 0;
        // name          op         op1           op2           rs1   rs2   rd     flags
        add_row("add",       ALU_ADD,   32'h00000005, 32'h00000007, 5'd0,  5'd0, 5'd1,  4'b0010,
                32'h0000000c);
        add_row("sub_wrap",  ALU_SUB,   32'h00000000, 32'h00000001, 5'd0,  5'd0, 5'd2,  4'b0010,
                32'hffffffff);
        add_row("slt_mixed", ALU_SLT,   32'hffffffff, 32'h00000001, 5'd0,  5'd0, 5'd3,  4'b0010,
                32'h00000001);
        add_row("sltu_mixed", ALU_SLTU, 32'hffffffff, 32'h00000001, 5'd0,  5'd0, 5'd4,  4'b0010,
                32'h00000000);
        add_row("sll_31",    ALU_SLL,   32'h00000001, 32'h0000001f, 5'd0,  5'd0, 5'd5,  4'b0010,
                32'h80000000);
        add_row("srl_0",     ALU_SRL,   32'h80000000, 32'h00000000, 5'd0,  5'd0, 5'd6,  4'b0010,
                32'h80000000);
        add_row("srl_31",    ALU_SRL,   32'h80000000, 32'h0000001f, 5'd0,  5'd0, 5'd7,  4'b0010,
                32'h00000001);
        add_row("sra_neg",   ALU_SRA,   32'h80000000, 32'h00000004, 5'd0,  5'd0, 5'd8,  4'b0010,
                32'hf8000000);
        add_row("sra_31",    ALU_SRA,   32'h80000000, 32'h0000001f, 5'd0,  5'd0, 5'd9,  4'b0010,
                32'hffffffff);
        add_row("xor",       ALU_XOR,   32'hf0f0f0f0, 32'h0ff00ff0, 5'd0,  5'd0, 5'd10, 4'b0010,
                32'hff00ff00);
        add_row("or",        ALU_OR,    32'h12340000, 32'h00005678, 5'd0,  5'd0, 5'd11, 4'b0010,
                32'h12345678);
        add_row("and",       ALU_AND,   32'hff00ff00, 32'h0ff00ff0, 5'd0,  5'd0, 5'd12, 4'b0010,
                32'h0f000f00);
        add_row("lui",       ALU_LUI,   32'hdeadbeef, 32'habcde000, 5'd0,  5'd0, 5'd13, 4'b0010,
                32'habcde000);
        add_row("auipc",     ALU_AUIPC, 32'h00001000, 32'h00002000, 5'd0,  5'd0, 5'd14, 4'b0010,
                32'h00003000);
        add_row("jump",      ALU_JUMP,  32'h00000100, 32'h00000004, 5'd0,  5'd0, 5'd15, 4'b0010,
                32'h00000104);
        // forwarding chain, stale table operands must be replaced
        add_row("fwd_src",   ALU_ADD,   32'h0000000a, 32'h00000014, 5'd0,  5'd0, 5'd16, 4'b0010,
                32'h0000001e);
        add_row("fwd_rs1",   ALU_ADD,   32'h00000999, 32'h00000001, 5'd16, 5'd0, 5'd17, 4'b1010,
                32'h0000001f);
        add_row("fwd_rs2",   ALU_SUB,   32'h00000100, 32'h00000555, 5'd0, 5'd17, 5'd18, 4'b0110,
                32'h000000e1);
        add_row("fwd_x0",    ALU_ADD,   32'h00000000, 32'h00000007, 5'd0,  5'd0, 5'd19, 4'b1010,
                32'h00000007);
        add_row("fwd_imm",   ALU_ADD,   32'h00000040, 32'h00000002, 5'd19, 5'd0, 5'd20, 4'b0010,
                32'h00000042);
        add_row("fwd_miss",  ALU_OR,    32'h00000011, 32'h00000022, 5'd5,  5'd0, 5'd21, 4'b1010,
                32'h00000033);
        add_row("fwd_both",  ALU_ADD,   32'h00000000, 32'h00000000, 5'd21, 5'd21, 5'd22, 4'b1110,
                32'h00000066);
        // flushed slot then a reader of its rd
        add_row("flush",     ALU_ADD,   32'h00001000, 32'h00000234, 5'd0,  5'd0, 5'd23, 4'b0011,
                32'h00001234);
        add_row("post_flush", ALU_ADD,  32'h00000050, 32'h00000005, 5'd23, 5'd0, 5'd24, 4'b1010,
                32'h00000055);
        add_row("no_we",     ALU_XOR,   32'h0000000a, 32'h00000005, 5'd0,  5'd0, 5'd0,  4'b0000,
                32'h0000000f);
        add_row("fwd_skip",  ALU_ADD,   32'h00000000, 32'h00000055, 5'd24, 5'd0, 5'd25, 4'b1010,
                32'h000000aa);
        if (n_rows != NUM_ROWS)
            abort_run("stimulus table size does not match the row count");
    endtask

    //////////////////////////////////////////////////////////////////////
    // clock, back-pressure, watchdog
    //////////////////////////////////////////////////////////////////////
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // random stall on the writeback port, roughly one cycle in four
    initial begin
        wb_ready_i = 1'b0;
        forever begin
            @(posedge clk);
            #5;
            wb_ready_i = (($random(seed) & 32'sd3) != 0);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("watchdog expired before all results came back");
    end

    // in-order result collector
    initial begin
        n_got = 0;
        @(posedge rst_n);
        while (n_got < NUM_ROWS) begin
            @(negedge clk);
            if (wb_valid_o && wb_ready_i) begin
                check_data(row_name[n_got], row_exp[n_got].data, wb_o.data);
                check_rd(row_name[n_got], row_exp[n_got].rd, wb_o.rd);
                check_we(row_name[n_got], row_exp[n_got].reg_we, wb_o.reg_we);
                check_id(row_name[n_got], row_exp[n_got].commit_id, wb_o.commit_id);
                n_got++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        rst_n         = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        flush_i       = 1'b0;
        build_table();

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        if (wb_valid_o)
            abort_run("writeback valid is high during reset");
        @(posedge clk);
        #5;
        rst_n = 1'b1;
        @(negedge clk);
        if (wb_valid_o || !issue_ready_o)
            abort_run("slice is not idle and ready after reset");

        @(posedge clk);
        #5;
        for (int i = 0; i < NUM_ROWS; i++) begin
            issue_valid_i = 1'b1;
            issue_i       = row_issue[i];
            flush_i       = row_flush[i];
            // accepted on the edge after a ready low phase
            do @(negedge clk); while (!issue_ready_o);
            @(posedge clk);
            #5;
        end
        issue_valid_i = 1'b0;
        issue_i       = '0;
        flush_i       = 1'b0;

        wait (n_got == NUM_ROWS);
        @(negedge clk);
        @(negedge clk);
        if (!wb_valid_o) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run("an extra result appeared after the last row");
        end
    end

endmodule

// File: build.f
+incdir+include
rtl/exu_types_pkg.sv
rtl/exu_if_pkg.sv
rtl/exu_fwd_ctrl.sv
rtl/exu_alu.sv
rtl/exu_wb_buffer.sv
rtl/exu_top.sv
verif/exu_checker.sv
verif/exu_tb.sv

// File: Makefile
# Verilator build and run for the execute slice

VERILATOR ?= verilator
TOP       ?= exu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run ended early, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
